//--- Bender.yml
package:
  name: rv_pipe

sources:
  - logic/rv_pkg.sv
  - logic/rv_alu.sv
  - logic/rv_regfile.sv
  - logic/rv_decoder.sv
  - logic/rv_hazard.sv
  - logic/rv_datapath.sv
  - logic/rv_core.sv
  - target: test
    files:
      - sim/tb_clock.sv
      - sim/tb_checker.sv
      - sim/tb_core.sv

//--- logic/rv_alu.sv
`timescale 1ns/1ps
`default_nettype none

module rv_alu
  import rv_pkg::*;
#(
  parameter int XLEN = 32
) (
  input  wire alu_op_e        i_op,
  input  wire  [XLEN-1:0]     i_a,
  input  wire  [XLEN-1:0]     i_b,
  output logic [XLEN-1:0]     o_result,
  output logic                o_zero
);

  logic [4:0] shamt;

  assign shamt = i_b[4:0];

  always_comb begin
    case (i_op)
      ADD:     o_result = i_a + i_b;
      SUB:     o_result = i_a - i_b;
      AND:     o_result = i_a & i_b;
      OR:      o_result = i_a | i_b;
      XOR:     o_result = i_a ^ i_b;
      // signed compare, result is 0 or 1
      SLT:     o_result = {{(XLEN-1){1'b0}}, ($signed(i_a) < $signed(i_b))};
      SLL:     o_result = i_a << shamt;
      SRL:     o_result = i_a >> shamt;
      PASS_B:  o_result = i_b;
      default: o_result = i_a + i_b;
    endcase
  end

  // beq/bne decide on this
  assign o_zero = (o_result == '0);

endmodule

`default_nettype wire

//--- logic/rv_core.sv
`timescale 1ns/1ps
`default_nettype none

module rv_core #(
  parameter int              XLEN     = 32,
  parameter logic [XLEN-1:0] RESET_PC = '0
) (
  input  wire               clk,
  input  wire               i_arst_n,
  output logic [XLEN-1:0]   o_imem_addr,
  input  wire  [31:0]       i_imem_data,
  output logic [XLEN-1:0]   o_dmem_addr,
  output logic [XLEN-1:0]   o_dmem_wdata,
  output logic              o_dmem_we,
  input  wire  [XLEN-1:0]   i_dmem_rdata
);

  rv_pkg::ctrl_t   ctrl;
  logic [XLEN-1:0] imm;
  logic [31:0]     d_inst;

  // hazard handshake between datapath and hazard unit
  logic [4:0] d_rs1, d_rs2, e_rs1, e_rs2, e_rd, m_rd, w_rd;
  logic       e_mem_read, m_reg_write, w_reg_write, e_branch_taken;
  logic [1:0] fwd_a, fwd_b;
  logic       stall_f_d, flush_d, flush_e;

  rv_decoder u_decoder (
    .i_inst (d_inst),
    .o_ctrl (ctrl),
    .o_imm  (imm)
  );

  rv_hazard u_hazard (
    .i_d_rs1 (d_rs1), .i_d_rs2 (d_rs2),
    .i_e_rs1 (e_rs1), .i_e_rs2 (e_rs2), .i_e_rd (e_rd),
    .i_e_mem_read (e_mem_read),
    .i_m_rd (m_rd), .i_m_reg_write (m_reg_write),
    .i_w_rd (w_rd), .i_w_reg_write (w_reg_write),
    .i_e_branch_taken (e_branch_taken),
    .o_fwd_a (fwd_a), .o_fwd_b (fwd_b),
    .o_stall_f_d (stall_f_d), .o_flush_d (flush_d), .o_flush_e (flush_e)
  );

  rv_datapath #(
    .XLEN (XLEN), .RESET_PC (RESET_PC)
  ) u_datapath (
    .clk (clk), .i_arst_n (i_arst_n),
    .i_inst (i_imem_data), .o_pc (o_imem_addr),
    .i_ctrl (ctrl), .i_imm (imm), .o_d_inst (d_inst),
    .o_d_rs1 (d_rs1), .o_d_rs2 (d_rs2),
    .o_e_rs1 (e_rs1), .o_e_rs2 (e_rs2), .o_e_rd (e_rd),
    .o_e_mem_read (e_mem_read),
    .o_m_rd (m_rd), .o_m_reg_write (m_reg_write),
    .o_w_rd (w_rd), .o_w_reg_write (w_reg_write),
    .o_e_branch_taken (e_branch_taken),
    .i_fwd_a (fwd_a), .i_fwd_b (fwd_b),
    .i_stall_f_d (stall_f_d), .i_flush_d (flush_d), .i_flush_e (flush_e),
    .o_dmem_addr (o_dmem_addr), .o_dmem_wdata (o_dmem_wdata),
    .o_dmem_we (o_dmem_we), .i_dmem_rdata (i_dmem_rdata)
  );

endmodule

`default_nettype wire

//--- logic/rv_datapath.sv
`timescale 1ns/1ps
`default_nettype none

module rv_datapath
  import rv_pkg::*;
#(
  parameter int              XLEN     = 32,
  parameter logic [XLEN-1:0] RESET_PC = '0
) (
  input  wire               clk,
  input  wire               i_arst_n,
  // instruction side
  input  wire  [31:0]       i_inst,
  output logic [XLEN-1:0]   o_pc,
  // decoder
  input  wire ctrl_t        i_ctrl,
  input  wire  [XLEN-1:0]   i_imm,
  output logic [31:0]       o_d_inst,
  // to hazard unit
  output logic [REG_AW-1:0] o_d_rs1,
  output logic [REG_AW-1:0] o_d_rs2,
  output logic [REG_AW-1:0] o_e_rs1,
  output logic [REG_AW-1:0] o_e_rs2,
  output logic [REG_AW-1:0] o_e_rd,
  output logic              o_e_mem_read,
  output logic [REG_AW-1:0] o_m_rd,
  output logic              o_m_reg_write,
  output logic [REG_AW-1:0] o_w_rd,
  output logic              o_w_reg_write,
  output logic              o_e_branch_taken,
  // from hazard unit
  input  wire  [1:0]        i_fwd_a,
  input  wire  [1:0]        i_fwd_b,
  input  wire               i_stall_f_d,
  input  wire               i_flush_d,
  input  wire               i_flush_e,
  // data side
  output logic [XLEN-1:0]   o_dmem_addr,
  output logic [XLEN-1:0]   o_dmem_wdata,
  output logic              o_dmem_we,
  input  wire  [XLEN-1:0]   i_dmem_rdata
);

  logic [XLEN-1:0] pc;
  logic [XLEN-1:0] d_pc;
  logic [31:0]     d_inst;
  opcode_e         d_opcode;
  logic [XLEN-1:0] d_rdata1;
  logic [XLEN-1:0] d_rdata2;

  idex_t  e;
  exmem_t m;
  memwb_t w;

  logic [XLEN-1:0] e_a;
  logic [XLEN-1:0] e_fwd_b;
  logic [XLEN-1:0] e_b;
  logic [XLEN-1:0] e_result;
  logic            e_zero;
  logic [XLEN-1:0] e_target;
  logic [XLEN-1:0] m_result;
  logic [XLEN-1:0] w_result;

  // fetch
  always_ff @(posedge clk or negedge i_arst_n) begin
    if (!i_arst_n) begin
      pc <= RESET_PC;
    end else if (o_e_branch_taken) begin
      pc <= e_target;
    end else if (!i_stall_f_d) begin
      pc <= pc + XLEN'(4);
    end
  end

  assign o_pc = pc;

  // fetch/decode register
  always_ff @(posedge clk or negedge i_arst_n) begin
    if (!i_arst_n) begin
      d_inst <= NOP_INST;
      d_pc   <= '0;
    end else if (i_flush_d) begin
      d_inst <= NOP_INST;
      d_pc   <= '0;
    end else if (!i_stall_f_d) begin
      d_inst <= i_inst;
      d_pc   <= pc;
    end
  end

  // decode
  assign o_d_inst = d_inst;
  assign d_opcode = opcode_e'(d_inst[6:0]);

  // only report sources the opcode really reads, avoids false stalls
  assign o_d_rs1 = (d_opcode == LUI || d_opcode == JAL) ? '0 : d_inst[19:15];
  assign o_d_rs2 = (d_opcode == OP || d_opcode == STORE || d_opcode == BRANCH) ?
                   d_inst[24:20] : '0;

  rv_regfile #(
    .XLEN (XLEN)
  ) u_regfile (
    .clk      (clk),
    .i_arst_n (i_arst_n),
    .i_we     (w.reg_write),
    .i_waddr  (w.rd),
    .i_raddr1 (o_d_rs1),
    .i_raddr2 (o_d_rs2),
    .i_wdata  (w_result),
    .o_rdata1 (d_rdata1),
    .o_rdata2 (d_rdata2)
  );

  // decode/execute register, flush inserts a bubble
  always_ff @(posedge clk or negedge i_arst_n) begin
    if (!i_arst_n) begin
      e <= '0;
    end else if (i_flush_e) begin
      e <= '0;
    end else begin
      e.ctrl     <= i_ctrl;
      e.pc       <= d_pc;
      e.rs1_data <= d_rdata1;
      e.rs2_data <= d_rdata2;
      e.imm      <= i_imm;
      e.rs1      <= o_d_rs1;
      e.rs2      <= o_d_rs2;
      e.rd       <= d_inst[11:7];
    end
  end

  // execute
  assign o_e_rs1      = e.rs1;
  assign o_e_rs2      = e.rs2;
  assign o_e_rd       = e.rd;
  assign o_e_mem_read = e.ctrl.mem_read;

  assign e_a = (i_fwd_a == FWD_MEM) ? m_result :
               (i_fwd_a == FWD_WB)  ? w_result : e.rs1_data;
  assign e_fwd_b = (i_fwd_b == FWD_MEM) ? m_result :
                   (i_fwd_b == FWD_WB)  ? w_result : e.rs2_data;
  assign e_b = e.ctrl.alu_src_imm ? e.imm : e_fwd_b;

  rv_alu #(
    .XLEN (XLEN)
  ) u_alu (
    .i_op     (e.ctrl.alu_op),
    .i_a      (e_a),
    .i_b      (e_b),
    .o_result (e_result),
    .o_zero   (e_zero)
  );

  assign e_target         = e.pc + e.imm;
  assign o_e_branch_taken = (e.ctrl.branch && (e_zero ^ e.ctrl.branch_ne)) || e.ctrl.jump;

  // execute/memory register
  always_ff @(posedge clk or negedge i_arst_n) begin
    if (!i_arst_n) begin
      m <= '0;
    end else begin
      m.reg_write  <= e.ctrl.reg_write;
      m.mem_write  <= e.ctrl.mem_write;
      m.wb_src     <= e.ctrl.wb_src;
      m.alu_result <= e_result;
      m.store_data <= e_fwd_b;
      m.pc_plus4   <= e.pc + XLEN'(4);
      m.rd         <= e.rd;
    end
  end

  // memory
  assign o_dmem_addr   = m.alu_result;
  assign o_dmem_wdata  = m.store_data;
  assign o_dmem_we     = m.mem_write;
  assign o_m_rd        = m.rd;
  assign o_m_reg_write = m.reg_write;

  assign m_result = (m.wb_src == WB_PC4) ? m.pc_plus4 :
                    (m.wb_src == WB_MEM) ? i_dmem_rdata : m.alu_result;

  // memory/writeback register, load data sampled here
  always_ff @(posedge clk or negedge i_arst_n) begin
    if (!i_arst_n) begin
      w <= '0;
    end else begin
      w.reg_write  <= m.reg_write;
      w.wb_src     <= m.wb_src;
      w.alu_result <= m.alu_result;
      w.load_data  <= i_dmem_rdata;
      w.pc_plus4   <= m.pc_plus4;
      w.rd         <= m.rd;
    end
  end

  // writeback
  always_comb begin
    case (w.wb_src)
      WB_MEM:  w_result = w.load_data;
      WB_PC4:  w_result = w.pc_plus4;
      default: w_result = w.alu_result;
    endcase
  end

  assign o_w_rd        = w.rd;
  assign o_w_reg_write = w.reg_write;

endmodule

`default_nettype wire

//--- logic/rv_decoder.sv
`timescale 1ns/1ps
`default_nettype none

module rv_decoder
  import rv_pkg::*;
(
  input  wire  [31:0]       i_inst,
  output ctrl_t             o_ctrl,
  output logic [DATA_W-1:0] o_imm
);

  opcode_e      opcode;
  logic [2:0]   funct3;
  logic         funct7_b5;
  alu_op_e      funct_op;

  logic [DATA_W-1:0] imm_i;
  logic [DATA_W-1:0] imm_s;
  logic [DATA_W-1:0] imm_b;
  logic [DATA_W-1:0] imm_u;
  logic [DATA_W-1:0] imm_j;

  assign opcode    = opcode_e'(i_inst[6:0]);
  assign funct3    = i_inst[14:12];
  assign funct7_b5 = i_inst[30];

  // immediate formats, all sign extended from bit 31
  assign imm_i = {{20{i_inst[31]}}, i_inst[31:20]};
  assign imm_s = {{20{i_inst[31]}}, i_inst[31:25], i_inst[11:7]};
  assign imm_b = {{19{i_inst[31]}}, i_inst[31], i_inst[7], i_inst[30:25], i_inst[11:8], 1'b0};
  assign imm_u = {i_inst[31:12], 12'b0};
  assign imm_j = {{11{i_inst[31]}}, i_inst[31], i_inst[19:12], i_inst[20], i_inst[30:21], 1'b0};

  // alu op from funct3, sub only for the register form
  always_comb begin
    case (funct3)
      3'b000:  funct_op = (opcode == OP && funct7_b5) ? SUB : ADD;
      3'b001:  funct_op = SLL;
      3'b010:  funct_op = SLT;
      3'b100:  funct_op = XOR;
      3'b101:  funct_op = SRL;
      3'b110:  funct_op = OR;
      3'b111:  funct_op = AND;
      default: funct_op = ADD;
    endcase
  end

  always_comb begin
    o_ctrl = '0;
    o_imm  = '0;
    case (opcode)
      OP: begin
        o_ctrl.alu_op    = funct_op;
        o_ctrl.reg_write = 1'b1;
      end
      OP_IMM: begin
        o_ctrl.alu_op      = funct_op;
        o_ctrl.alu_src_imm = 1'b1;
        o_ctrl.reg_write   = 1'b1;
        o_imm              = imm_i;
      end
      LUI: begin
        o_ctrl.alu_op      = PASS_B;
        o_ctrl.alu_src_imm = 1'b1;
        o_ctrl.reg_write   = 1'b1;
        o_imm              = imm_u;
      end
      LOAD: begin
        o_ctrl.alu_src_imm = 1'b1;
        o_ctrl.reg_write   = 1'b1;
        o_ctrl.mem_read    = 1'b1;
        o_ctrl.wb_src      = WB_MEM;
        o_imm              = imm_i;
      end
      STORE: begin
        o_ctrl.alu_src_imm = 1'b1;
        o_ctrl.mem_write   = 1'b1;
        o_imm              = imm_s;
      end
      BRANCH: begin
        // compare by subtraction, zero flag decides
        o_ctrl.alu_op    = SUB;
        o_ctrl.branch    = 1'b1;
        o_ctrl.branch_ne = funct3[0];
        o_imm            = imm_b;
      end
      JAL: begin
        o_ctrl.reg_write = 1'b1;
        o_ctrl.jump      = 1'b1;
        o_ctrl.wb_src    = WB_PC4;
        o_imm            = imm_j;
      end
      default: begin
        // unknown opcode acts as a nop
        o_ctrl = '0;
      end
    endcase
  end

endmodule

`default_nettype wire

//--- logic/rv_hazard.sv
`timescale 1ns/1ps
`default_nettype none

module rv_hazard
  import rv_pkg::*;
(
  input  wire  [REG_AW-1:0] i_d_rs1,
  input  wire  [REG_AW-1:0] i_d_rs2,
  input  wire  [REG_AW-1:0] i_e_rs1,
  input  wire  [REG_AW-1:0] i_e_rs2,
  input  wire  [REG_AW-1:0] i_e_rd,
  input  wire               i_e_mem_read,
  input  wire  [REG_AW-1:0] i_m_rd,
  input  wire               i_m_reg_write,
  input  wire  [REG_AW-1:0] i_w_rd,
  input  wire               i_w_reg_write,
  input  wire               i_e_branch_taken,
  output logic [1:0]        o_fwd_a,
  output logic [1:0]        o_fwd_b,
  output logic              o_stall_f_d,
  output logic              o_flush_d,
  output logic              o_flush_e
);

  logic m_valid;
  logic w_valid;
  logic load_use;

  // x0 never forwards
  assign m_valid = i_m_reg_write && (i_m_rd != '0);
  assign w_valid = i_w_reg_write && (i_w_rd != '0);

  // memory stage wins over writeback
  assign o_fwd_a = (m_valid && i_m_rd == i_e_rs1) ? FWD_MEM :
                   (w_valid && i_w_rd == i_e_rs1) ? FWD_WB  : FWD_REG;
  assign o_fwd_b = (m_valid && i_m_rd == i_e_rs2) ? FWD_MEM :
                   (w_valid && i_w_rd == i_e_rs2) ? FWD_WB  : FWD_REG;

  assign load_use = i_e_mem_read && (i_e_rd != '0) &&
                    ((i_e_rd == i_d_rs1) || (i_e_rd == i_d_rs2));

  // a taken branch discards the stalled pair anyway
  assign o_stall_f_d = load_use && !i_e_branch_taken;
  assign o_flush_d   = i_e_branch_taken;
  assign o_flush_e   = load_use || i_e_branch_taken;

endmodule

`default_nettype wire

//--- logic/rv_pkg.sv
`default_nettype none

package rv_pkg;

  // struct field width, matches the XLEN parameter of the core
  localparam int DATA_W = 32;
  localparam int REG_AW = 5;

  // addi x0, x0, 0
  localparam logic [31:0] NOP_INST = 32'h0000_0013;

  // forwarding selects from the hazard unit
  localparam logic [1:0] FWD_REG = 2'd0;
  localparam logic [1:0] FWD_MEM = 2'd1;
  localparam logic [1:0] FWD_WB  = 2'd2;

  typedef enum logic [6:0] {
    OP     = 7'b0110011,
    OP_IMM = 7'b0010011,
    LUI    = 7'b0110111,
    LOAD   = 7'b0000011,
    STORE  = 7'b0100011,
    BRANCH = 7'b1100011,
    JAL    = 7'b1101111
  } opcode_e;

  typedef enum logic [3:0] {
    ADD, SUB, AND, OR, XOR, SLT, SLL, SRL, PASS_B
  } alu_op_e;

  typedef enum logic [1:0] {
    WB_ALU,
    WB_MEM,
    WB_PC4
  } wb_src_e;

  typedef struct packed {
    alu_op_e alu_op;
    logic    alu_src_imm;
    logic    reg_write;
    logic    mem_read;
    logic    mem_write;
    logic    branch;
    logic    branch_ne;
    logic    jump;
    wb_src_e wb_src;
  } ctrl_t;

  typedef struct packed {
    ctrl_t              ctrl;
    logic [DATA_W-1:0]  pc;
    logic [DATA_W-1:0]  rs1_data;
    logic [DATA_W-1:0]  rs2_data;
    logic [DATA_W-1:0]  imm;
    logic [REG_AW-1:0]  rs1;
    logic [REG_AW-1:0]  rs2;
    logic [REG_AW-1:0]  rd;
  } idex_t;

  typedef struct packed {
    logic               reg_write;
    logic               mem_write;
    wb_src_e            wb_src;
    logic [DATA_W-1:0]  alu_result;
    logic [DATA_W-1:0]  store_data;
    logic [DATA_W-1:0]  pc_plus4;
    logic [REG_AW-1:0]  rd;
  } exmem_t;

  typedef struct packed {
    logic               reg_write;
    wb_src_e            wb_src;
    logic [DATA_W-1:0]  alu_result;
    logic [DATA_W-1:0]  load_data;
    logic [DATA_W-1:0]  pc_plus4;
    logic [REG_AW-1:0]  rd;
  } memwb_t;

endpackage

`default_nettype wire

//--- logic/rv_regfile.sv
`timescale 1ns/1ps
`default_nettype none

module rv_regfile
  import rv_pkg::*;
#(
  parameter int XLEN = 32
) (
  input  wire               clk,
  input  wire               i_arst_n,
  input  wire               i_we,
  input  wire  [REG_AW-1:0] i_waddr,
  input  wire  [REG_AW-1:0] i_raddr1,
  input  wire  [REG_AW-1:0] i_raddr2,
  input  wire  [XLEN-1:0]   i_wdata,
  output logic [XLEN-1:0]   o_rdata1,
  output logic [XLEN-1:0]   o_rdata2
);

  logic [XLEN-1:0] regs [2**REG_AW];
  logic            wr_valid;

  // x0 stays zero, writes to it dropped
  assign wr_valid = i_we && (i_waddr != '0);

  always_ff @(posedge clk or negedge i_arst_n) begin
    if (!i_arst_n) begin
      for (int i = 0; i < 2**REG_AW; i++) begin
        regs[i] <= '0;
      end
    end else if (wr_valid) begin
      regs[i_waddr] <= i_wdata;
    end
  end

  // same-cycle write shows up on the reads
  assign o_rdata1 = (wr_valid && i_waddr == i_raddr1) ? i_wdata : regs[i_raddr1];
  assign o_rdata2 = (wr_valid && i_waddr == i_raddr2) ? i_wdata : regs[i_raddr2];

endmodule

`default_nettype wire

//--- rv_pipe.f
logic/rv_pkg.sv
logic/rv_alu.sv
logic/rv_regfile.sv
logic/rv_decoder.sv
logic/rv_hazard.sv
logic/rv_datapath.sv
logic/rv_core.sv
sim/tb_clock.sv
sim/tb_checker.sv
sim/tb_core.sv

//--- sim/tb_checker.sv
`timescale 1ns/1ps
`default_nettype none

module tb_checker #(
  parameter logic [31:0] RESET_PC = 32'h0
) (
  input wire        clk,
  input wire        i_arst_n,
  input wire [31:0] i_imem_addr,
  input wire        i_dmem_we,
  input wire [31:0] i_dmem_addr,
  input wire [31:0] i_dmem_wdata
);

  localparam logic [31:0] MARKER_ADDR = 32'h0000_03fc;
  localparam int          MAX_STEPS   = 4000;

  logic [31:0] prog [256];
  logic [31:0] init_data [256];
  logic [31:0] exp_addr [$];
  logic [31:0] exp_data [$];
  logic [31:0] want_addr;
  logic [31:0] want_data;
  string       test_name;
  int          test_errors;
  int          pass_count;
  int          fail_count;

  initial begin
    test_errors = 0;
    pass_count  = 0;
    fail_count  = 0;
  end

  // sequential instruction-set model without a pipeline
  function automatic bit run_reference();
    logic [31:0] x [32];
    logic [31:0] mem [256];
    logic [31:0] pc;
    logic [31:0] next_pc;
    logic [31:0] inst;
    logic [31:0] a;
    logic [31:0] b;
    logic [31:0] r;
    logic [31:0] imm;
    logic [31:0] ea;
    logic [2:0]  f3;
    bit          wr;
    for (int i = 0; i < 256; i++) begin
      mem[i] = init_data[i];
    end
    for (int i = 0; i < 32; i++) begin
      x[i] = '0;
    end
    pc = RESET_PC;
    for (int step = 0; step < MAX_STEPS; step++) begin
      inst    = prog[pc[9:2]];
      f3      = inst[14:12];
      a       = x[inst[19:15]];
      b       = x[inst[24:20]];
      imm     = {{20{inst[31]}}, inst[31:20]};
      next_pc = pc + 32'd4;
      wr      = 1'b0;
      r       = '0;
      case (inst[6:0])
        7'h33: begin
          wr = 1'b1;
          case (f3)
            3'd0:    r = inst[30] ? a - b : a + b;
            3'd1:    r = a << b[4:0];
            3'd2:    r = ($signed(a) < $signed(b)) ? 32'd1 : 32'd0;
            3'd4:    r = a ^ b;
            3'd5:    r = a >> b[4:0];
            3'd6:    r = a | b;
            default: r = a & b;
          endcase
        end
        7'h13: begin
          wr = 1'b1;
          case (f3)
            3'd0:    r = a + imm;
            3'd2:    r = ($signed(a) < $signed(imm)) ? 32'd1 : 32'd0;
            3'd4:    r = a ^ imm;
            3'd6:    r = a | imm;
            default: r = a & imm;
          endcase
        end
        7'h37: begin
          wr = 1'b1;
          r  = {inst[31:12], 12'h000};
        end
        7'h03: begin
          wr = 1'b1;
          ea = a + imm;
          r  = mem[ea[9:2]];
        end
        7'h23: begin
          ea = a + {{20{inst[31]}}, inst[31:25], inst[11:7]};
          exp_addr.push_back(ea);
          exp_data.push_back(b);
          mem[ea[9:2]] = b;
          if (ea == MARKER_ADDR) begin
            return 1'b1;
          end
        end
        7'h63: begin
          // funct3 bit 0 set means bne
          if ((a == b) != f3[0]) begin
            next_pc = pc + {{19{inst[31]}}, inst[31], inst[7], inst[30:25], inst[11:8], 1'b0};
          end
        end
        7'h6f: begin
          wr      = 1'b1;
          r       = pc + 32'd4;
          next_pc = pc + {{11{inst[31]}}, inst[31], inst[19:12], inst[20], inst[30:21], 1'b0};
        end
        default: begin
          wr = 1'b0;
        end
      endcase
      if (wr && inst[11:7] != 5'd0) begin
        x[inst[11:7]] = r;
      end
      pc = next_pc;
    end
    return 1'b0;
  endfunction

  task automatic load_word(input int idx, input logic [31:0] inst, input logic [31:0] data);
    prog[idx]      = inst;
    init_data[idx] = data;
  endtask

  task automatic start_test(input string name);
    test_name = name;
    exp_addr.delete();
    exp_data.delete();
    if (!run_reference()) begin
      $display("test %s: reference model never reached the end marker", name);
      test_errors++;
    end
  endtask

  task automatic finish_test(input bit timed_out);
    if (timed_out) begin
      test_errors++;
    end
    if (exp_addr.size() != 0) begin
      $display("test %s: %0d expected stores never appeared", test_name, exp_addr.size());
      test_errors++;
    end
    if (test_errors == 0) begin
      pass_count++;
      $display("test %s: passed", test_name);
    end else begin
      fail_count++;
      $display("test %s: failed with %0d errors", test_name, test_errors);
    end
    test_errors = 0;
  endtask

  task automatic report();
    $display("tests run: %0d, passed: %0d, failed: %0d",
             pass_count + fail_count, pass_count, fail_count);
  endtask

  function automatic int failed_tests();
    return fail_count;
  endfunction

  // store stream compare on the rising edge
  always @(posedge clk) begin
    if (!i_arst_n) begin
      if (i_dmem_we !== 1'b0) begin
        $display("error at %0t ns: o_dmem_we expected 0, actual %b", $time, i_dmem_we);
        test_errors++;
      end
      if (i_imem_addr !== RESET_PC) begin
        $display("error at %0t ns: o_imem_addr expected %h, actual %h",
                 $time, RESET_PC, i_imem_addr);
        test_errors++;
      end
    end else if (i_dmem_we !== 1'b0) begin
      if (exp_addr.size() == 0) begin
        $display("unexpected store to %h at %0t ns, no store was expected", i_dmem_addr, $time);
        test_errors++;
      end else begin
        want_addr = exp_addr.pop_front();
        want_data = exp_data.pop_front();
        if (i_dmem_addr !== want_addr) begin
          $display("error at %0t ns: o_dmem_addr expected %h, actual %h",
                   $time, want_addr, i_dmem_addr);
          test_errors++;
        end
        if (i_dmem_wdata !== want_data) begin
          $display("error at %0t ns: o_dmem_wdata expected %h, actual %h",
                   $time, want_data, i_dmem_wdata);
          test_errors++;
        end
      end
    end
  end

endmodule

`default_nettype wire

//--- sim/tb_clock.sv
`timescale 1ns/1ps
`default_nettype none

module tb_clock #(
  parameter int PERIOD_NS = 20
) (
  output logic o_clk,
  output logic o_rst_n
);

  // power-on reset, two cycles, released on a falling edge
  initial begin
    o_clk   = 1'b0;
    o_rst_n = 1'b0;
    repeat (2) @(posedge o_clk);
    @(negedge o_clk);
    o_rst_n = 1'b1;
  end

  always #(PERIOD_NS / 2) o_clk = ~o_clk;

endmodule

`default_nettype wire

//--- sim/tb_core.sv
`timescale 1ns/1ps
`default_nettype none

module tb_core
  import rv_pkg::*;
();

  localparam logic [31:0] SEED        = 32'hec26_3793;
  localparam logic [31:0] RESET_PC    = 32'h0;
  localparam logic [31:0] MARKER_ADDR = 32'h0000_03fc;
  localparam int          TIMEOUT     = 2000;
  localparam logic [2:0]  F3_ADD      = 3'd0;
  localparam logic [2:0]  F3_SLL      = 3'd1;
  localparam logic [2:0]  F3_SLT      = 3'd2;
  localparam logic [2:0]  F3_XOR      = 3'd4;
  localparam logic [2:0]  F3_SRL      = 3'd5;
  localparam logic [2:0]  F3_OR       = 3'd6;
  localparam logic [2:0]  F3_AND      = 3'd7;

  logic        clk;
  logic        por_n;
  logic        test_rst_n;
  logic        arst_n;
  logic [31:0] imem_addr;
  logic [31:0] imem_data;
  logic [31:0] dmem_addr;
  logic [31:0] dmem_wdata;
  logic [31:0] dmem_rdata;
  logic        dmem_we;
  logic [31:0] imem [256];
  logic [31:0] dmem [256];
  logic [31:0] lfsr;
  int          prog_len;
  int          st_addr;

  tb_clock u_clock (
    .o_clk   (clk),
    .o_rst_n (por_n)
  );

  assign arst_n = por_n && test_rst_n;

  rv_core #(
    .XLEN     (32),
    .RESET_PC (RESET_PC)
  ) i_dut (
    .clk          (clk),
    .i_arst_n     (arst_n),
    .o_imem_addr  (imem_addr),
    .i_imem_data  (imem_data),
    .o_dmem_addr  (dmem_addr),
    .o_dmem_wdata (dmem_wdata),
    .o_dmem_we    (dmem_we),
    .i_dmem_rdata (dmem_rdata)
  );

  tb_checker #(
    .RESET_PC (RESET_PC)
  ) u_checker (
    .clk          (clk),
    .i_arst_n     (arst_n),
    .i_imem_addr  (imem_addr),
    .i_dmem_we    (dmem_we),
    .i_dmem_addr  (dmem_addr),
    .i_dmem_wdata (dmem_wdata)
  );

  // both memories read combinationally by word index
  assign imem_data  = imem[imem_addr[9:2]];
  assign dmem_rdata = dmem[dmem_addr[9:2]];

  always @(posedge clk) begin
    if (dmem_we === 1'b1) begin
      dmem[dmem_addr[9:2]] <= dmem_wdata;
    end
  end

  function automatic logic [31:0] data_fill(input int idx);
    return {8'hd5, 8'(idx), 8'(idx * 7 + 3), ~8'(idx)};
  endfunction

  // galois lfsr on x^32 + x^22 + x^2 + x + 1
  function automatic logic [31:0] lfsr_step(input logic [31:0] s);
    return s[0] ? ((s >> 1) ^ 32'h8020_0003) : (s >> 1);
  endfunction

  function automatic logic [31:0] rand_bits(input int n);
    logic [31:0] v;
    v = '0;
    for (int k = 0; k < n; k++) begin
      v    = {v[30:0], lfsr[0]};
      lfsr = lfsr_step(lfsr);
    end
    return v;
  endfunction

  function automatic logic [4:0] pick_reg();
    logic [4:0] r;
    r = 5'(rand_bits(3));
    return (r == 5'd0) ? 5'd7 : r;
  endfunction

  function automatic logic [31:0] encode_r(input logic [6:0] f7, input logic [2:0] f3,
                                           input logic [4:0] rd, input logic [4:0] rs1,
                                           input logic [4:0] rs2);
    return {f7, rs2, rs1, f3, rd, 7'h33};
  endfunction

  // opcode 13 for alu immediates and 03 for lw
  function automatic logic [31:0] encode_i(input logic [6:0] opc, input logic [2:0] f3,
                                           input logic [4:0] rd, input logic [4:0] rs1,
                                           input logic [11:0] imm);
    return {imm, rs1, f3, rd, opc};
  endfunction

  function automatic logic [31:0] encode_s(input logic [4:0] rs2, input logic [4:0] rs1,
                                           input logic [11:0] imm);
    return {imm[11:5], rs2, rs1, 3'b010, imm[4:0], 7'h23};
  endfunction

  function automatic logic [31:0] encode_b(input logic [2:0] f3, input logic [4:0] rs1,
                                           input logic [4:0] rs2, input logic [12:0] imm);
    return {imm[12], imm[10:5], rs2, rs1, f3, imm[4:1], imm[11], 7'h63};
  endfunction

  function automatic logic [31:0] encode_u(input logic [4:0] rd, input logic [19:0] imm);
    return {imm, rd, 7'h37};
  endfunction

  function automatic logic [31:0] encode_j(input logic [4:0] rd, input logic [20:0] imm);
    return {imm[20], imm[10:1], imm[11], imm[19:12], rd, 7'h6f};
  endfunction

  // hold the core in reset while a new program goes in
  task automatic begin_program();
    @(negedge clk);
    test_rst_n = 1'b0;
    prog_len   = 0;
    st_addr    = 32'h100;
    for (int i = 0; i < 256; i++) begin
      imem[i] = NOP_INST;
      dmem[i] <= data_fill(i);
    end
  endtask

  task automatic emit(input logic [31:0] inst);
    imem[prog_len] = inst;
    prog_len++;
  endtask

  task automatic emit_store(input logic [4:0] rs);
    emit(encode_s(rs, 5'd0, 12'(st_addr)));
    st_addr += 4;
  endtask

  // instruction followed by a store of its destination
  task automatic emit_and_store(input logic [31:0] inst);
    emit(inst);
    emit_store(inst[11:7]);
  endtask

  // word addresses below 128 and forward jumps only
  task automatic emit_random(input int count);
    logic [2:0] kind;
    logic [2:0] f3;
    logic [4:0] rd;
    logic [4:0] rs1;
    logic [4:0] rs2;
    while (prog_len < count) begin
      kind = 3'(rand_bits(3));
      rd   = pick_reg();
      rs1  = pick_reg();
      rs2  = pick_reg();
      f3   = 3'(rand_bits(3));
      case (kind)
        3'd0: begin
          if (f3 == 3'd3) begin
            f3 = F3_ADD;
          end
          emit(encode_r((f3 == F3_ADD && rand_bits(1) == 1) ? 7'h20 : 7'h00, f3, rd, rs1, rs2));
        end
        3'd2: emit(encode_u(rd, 20'(rand_bits(20))));
        3'd3: begin
          emit(encode_i(7'h13, F3_AND, rd, rs1, 12'h1fc));
          emit(encode_i(7'h03, 3'b010, rs2, rd, 12'h000));
        end
        3'd4: begin
          emit(encode_i(7'h13, F3_AND, rd, rs1, 12'h1fc));
          emit(encode_s(rs2, rd, 12'h000));
        end
        3'd5: emit(encode_b({2'b00, f3[0]}, rs1, rs2, 13'((1 + rand_bits(2)) * 4)));
        3'd6: emit(encode_j(rd, 21'((1 + rand_bits(2)) * 4)));
        default: begin
          // only addi slti xori ori and andi
          if (f3[0] && f3 != 3'd7) begin
            f3 = f3 - 3'd1;
          end
          emit(encode_i(7'h13, f3, rd, rs1, 12'(rand_bits(12))));
        end
      endcase
    end
  endtask

  task automatic run_test(input string name);
    int cycles;
    bit seen;
    emit(encode_s(5'd0, 5'd0, 12'h3fc));
    emit(encode_j(5'd0, 21'd0));
    for (int i = 0; i < 256; i++) begin
      u_checker.load_word(i, imem[i], data_fill(i));
    end
    u_checker.start_test(name);
    repeat (2) @(negedge clk);
    test_rst_n = 1'b1;
    cycles     = 0;
    seen       = 1'b0;
    while (!seen && cycles < TIMEOUT) begin
      @(negedge clk);
      cycles++;
      seen = (dmem_we === 1'b1) && (dmem_addr === MARKER_ADDR);
    end
    if (!seen) begin
      $display("test %s: no store to the end marker within %0d cycles", name, TIMEOUT);
    end
    // one more edge so the checker sees the marker store
    @(negedge clk);
    u_checker.finish_test(!seen);
  endtask

  initial begin
    lfsr       = SEED;
    test_rst_n = 1'b1;
    prog_len   = 0;
    st_addr    = 0;
    for (int i = 0; i < 256; i++) begin
      imem[i] = NOP_INST;
      dmem[i] <= data_fill(i);
    end

    // writes to x0 including one that would forward from the memory stage
    begin_program();
    emit(encode_i(7'h13, F3_ADD, 5'd0, 5'd0, 12'h7ab));
    emit_store(5'd0);
    emit(encode_i(7'h13, F3_ADD, 5'd1, 5'd0, 12'd3));
    emit(encode_r(7'h00, F3_ADD, 5'd0, 5'd1, 5'd1));
    emit_store(5'd0);
    run_test("reset_x0");

    begin_program();
    emit_and_store(encode_i(7'h13, F3_ADD, 5'd1, 5'd0, 12'h5a3));
    emit_and_store(encode_u(5'd2, 20'hf0f0f));
    emit_and_store(encode_r(7'h00, F3_ADD, 5'd3, 5'd2, 5'd1));
    emit_and_store(encode_r(7'h20, F3_ADD, 5'd4, 5'd3, 5'd1));
    emit_and_store(encode_r(7'h00, F3_XOR, 5'd5, 5'd4, 5'd3));
    emit_and_store(encode_r(7'h00, F3_OR, 5'd6, 5'd5, 5'd2));
    emit_and_store(encode_r(7'h00, F3_AND, 5'd7, 5'd6, 5'd3));
    emit_and_store(encode_r(7'h00, F3_SLT, 5'd1, 5'd4, 5'd7));
    emit_and_store(encode_i(7'h13, F3_ADD, 5'd1, 5'd1, 12'd10));
    emit_and_store(encode_r(7'h00, F3_SLL, 5'd2, 5'd7, 5'd1));
    emit_and_store(encode_r(7'h00, F3_SRL, 5'd3, 5'd2, 5'd1));
    emit_and_store(encode_i(7'h13, F3_XOR, 5'd4, 5'd3, 12'hfff));
    emit_and_store(encode_i(7'h13, F3_OR, 5'd5, 5'd4, 12'h0f0));
    emit_and_store(encode_i(7'h13, F3_AND, 5'd6, 5'd5, 12'h7f3));
    emit_and_store(encode_i(7'h13, F3_SLT, 5'd7, 5'd4, 12'h005));
    // back to back so operands come from the memory stage
    emit(encode_r(7'h00, F3_ADD, 5'd1, 5'd6, 5'd7));
    emit(encode_r(7'h20, F3_ADD, 5'd2, 5'd1, 5'd6));
    emit_and_store(encode_r(7'h00, F3_XOR, 5'd3, 5'd2, 5'd1));
    run_test("alu_chain");

    begin_program();
    emit(encode_i(7'h03, 3'b010, 5'd1, 5'd0, 12'h040));
    emit_and_store(encode_r(7'h00, F3_ADD, 5'd2, 5'd1, 5'd1));
    emit(encode_i(7'h03, 3'b010, 5'd3, 5'd0, 12'h044));
    emit_store(5'd3);
    emit(encode_i(7'h03, 3'b010, 5'd4, 5'd0, 12'h048));
    emit_and_store(encode_r(7'h00, F3_ADD, 5'd5, 5'd4, 5'd3));
    run_test("load_use");

    // stores in the two slots after a taken branch must never show
    begin_program();
    emit(encode_i(7'h13, F3_ADD, 5'd1, 5'd0, 12'd5));
    emit(encode_i(7'h13, F3_ADD, 5'd2, 5'd0, 12'd5));
    emit(encode_i(7'h13, F3_ADD, 5'd3, 5'd0, 12'd9));
    emit(encode_b(3'b000, 5'd1, 5'd2, 13'd12));
    emit(encode_s(5'd1, 5'd0, 12'h180));
    emit(encode_s(5'd2, 5'd0, 12'h184));
    emit_store(5'd3);
    emit(encode_b(3'b001, 5'd1, 5'd2, 13'd12));
    emit_store(5'd1);
    emit_store(5'd2);
    emit(encode_b(3'b001, 5'd1, 5'd3, 13'd12));
    emit(encode_s(5'd1, 5'd0, 12'h188));
    emit(encode_s(5'd3, 5'd0, 12'h18c));
    emit(encode_b(3'b000, 5'd1, 5'd3, 13'd12));
    emit_store(5'd3);
    emit_store(5'd1);
    run_test("branches");

    begin_program();
    emit(encode_i(7'h13, F3_ADD, 5'd1, 5'd0, 12'd1));
    emit(encode_j(5'd5, 21'd12));
    emit(encode_s(5'd1, 5'd0, 12'h180));
    emit(encode_s(5'd1, 5'd0, 12'h184));
    emit_store(5'd5);
    emit(encode_j(5'd6, 21'd8));
    emit(encode_s(5'd1, 5'd0, 12'h188));
    emit_store(5'd6);
    run_test("jal_link");

    for (int p = 0; p < 4; p++) begin
      begin_program();
      emit_random(40);
      for (int r = 1; r < 8; r++) begin
        emit(encode_s(5'(r), 5'd0, 12'(32'h300 + 4 * r)));
      end
      run_test($sformatf("random_%0d", p));
    end

    u_checker.report();
    if (u_checker.failed_tests() == 0) begin
      $display("Result: PASSED");
    end else begin
      $display("Result: FAILED");
    end
    $finish;
  end

endmodule

`default_nettype wire
